/* aluArith.sv */
`timescale 1ns/1ns
`default_nettype none

module aluArith
(
  input  logic           clk,
  input  logic           rst,
  input  logic           opValid,
  input  aluPkg::aluOp_t op,
  input  aluPkg::data_t  a,
  input  aluPkg::data_t  b,
  output logic           arithValid,
  output aluPkg::data_t  arithResult,
  output logic           arithCarry,
  output logic           arithOverflow
);

  logic                       claim;
  logic [aluPkg::dataWidth:0] sumWide;   // Carry out in top bit
  logic [aluPkg::dataWidth:0] diffWide;  // Borrow in top bit
  logic                       addOverflow;
  logic                       subOverflow;
  logic                       lessSigned;
  logic                       lessUnsigned;
  aluPkg::data_t              nextResult;
  logic                       nextCarry;
  logic                       nextOverflow;

  // Everything from opAnd up to opSltu is ours
  assign claim = (op <= aluPkg::opSltu);

  // One adder and one subtractor serve signed and unsigned forms
  assign sumWide  = {1'b0, a} + {1'b0, b};
  assign diffWide = {1'b0, a} - {1'b0, b};

  // Same signs in, different sign out
  assign addOverflow = (a[aluPkg::signBit] == b[aluPkg::signBit]) &&
                       (sumWide[aluPkg::signBit] != a[aluPkg::signBit]);

  // Different signs in, result sign flips away from a
  assign subOverflow = (a[aluPkg::signBit] != b[aluPkg::signBit]) &&
                       (diffWide[aluPkg::signBit] != a[aluPkg::signBit]);

  // Sign of a - b, corrected when the subtraction overflowed
  assign lessSigned   = diffWide[aluPkg::signBit] ^ subOverflow;
  assign lessUnsigned = diffWide[aluPkg::dataWidth];  // Borrow

  always_comb
  begin
    nextResult   = '0;
    nextCarry    = 1'b0;
    nextOverflow = 1'b0;
    case (op)
      aluPkg::opAnd:  nextResult = a & b;
      aluPkg::opOr:   nextResult = a | b;
      aluPkg::opXor:  nextResult = a ^ b;
      aluPkg::opNand: nextResult = ~(a & b);
      aluPkg::opNor:  nextResult = ~(a | b);
      aluPkg::opXnor: nextResult = ~(a ^ b);
      aluPkg::opAddU:
      begin
        nextResult = sumWide[aluPkg::signBit:0];
        nextCarry  = sumWide[aluPkg::dataWidth];
      end
      aluPkg::opSubU:
      begin
        nextResult = diffWide[aluPkg::signBit:0];
        nextCarry  = diffWide[aluPkg::dataWidth];  // 1 when a < b
      end
      aluPkg::opAddS:
      begin
        nextResult   = sumWide[aluPkg::signBit:0];
        nextOverflow = addOverflow;
      end
      aluPkg::opSubS:
      begin
        nextResult   = diffWide[aluPkg::signBit:0];
        nextOverflow = subOverflow;
      end
      aluPkg::opSlt:  nextResult = {{aluPkg::signBit{1'b0}}, lessSigned};
      aluPkg::opSltu: nextResult = {{aluPkg::signBit{1'b0}}, lessUnsigned};
      default:        nextResult = '0;  // Shift unit ops
    endcase
  end

  // Strobe only for claimed ops
  always_ff @(posedge clk)
  begin
    if (rst)
      arithValid <= 1'b0;
    else
      arithValid <= opValid && claim;
  end

  // Payload holds between strobes
  always_ff @(posedge clk)
  begin
    if (opValid && claim)
    begin
      arithResult   <= nextResult;
      arithCarry    <= nextCarry;
      arithOverflow <= nextOverflow;
    end
  end

endmodule

`default_nettype wire

/* aluBitCount.sv */
`timescale 1ns/1ns
`default_nettype none

module aluBitCount
(
  input  logic           clk,
  input  logic           rst,
  input  logic           opValid,
  input  aluPkg::aluOp_t op,
  input  aluPkg::data_t  a,
  input  aluPkg::data_t  b,
  output logic           shiftValid,
  output aluPkg::data_t  shiftResult
);

  logic           claim;
  aluPkg::shamt_t shamt;
  aluPkg::data_t  scanWord;
  aluPkg::count_t leadCount;
  aluPkg::data_t  countWide;
  aluPkg::data_t  nextResult;

  // Upper four codes belong here
  assign claim = (op >= aluPkg::opSllv);

  // Amount from low bits of b only
  assign shamt = b[aluPkg::shamtWidth-1:0];

  // Counting leading zeros is counting leading ones of ~a
  assign scanWord = (op == aluPkg::opClo) ? a : ~a;

  // Priority scan from bit 31 down
  // The highest clear bit decides the count
  always_comb
  begin
    leadCount = aluPkg::count_t'(aluPkg::dataWidth);  // All ones case
    for (int i = 0; i < aluPkg::dataWidth; i++)
    begin
      if (!scanWord[i])
        leadCount = aluPkg::count_t'(aluPkg::signBit - i);
    end
  end

  assign countWide = {{(aluPkg::dataWidth - aluPkg::countWidth){1'b0}}, leadCount};

  always_comb
  begin
    case (op)
      aluPkg::opSllv: nextResult = a << shamt;
      aluPkg::opSrlv: nextResult = a >> shamt;  // Logical, zero fill
      aluPkg::opClo,
      aluPkg::opClz:  nextResult = countWide;
      default:        nextResult = '0;          // Arithmetic unit ops
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      shiftValid <= 1'b0;
    else
      shiftValid <= opValid && claim;
  end

  // Result register, loads on claimed ops only
  always_ff @(posedge clk)
  begin
    if (opValid && claim)
      shiftResult <= nextResult;
  end

endmodule

`default_nettype wire

/* aluPkg.sv */
`default_nettype none

package aluPkg;

  // Operand and result width
  localparam int dataWidth = 32;

  // Index of the sign bit
  localparam int signBit = dataWidth - 1;

  // Shift amount comes from the low bits of b
  localparam int shamtWidth = $clog2(dataWidth);

  // Leading-bit count spans 0 to dataWidth inclusive
  localparam int countWidth = $clog2(dataWidth + 1);

  // Operation code width
  localparam int opWidth = 4;

  typedef logic [dataWidth-1:0]  data_t;   // Operands and result
  typedef logic [shamtWidth-1:0] shamt_t;  // Shift amount
  typedef logic [countWidth-1:0] count_t;  // Leading ones or zeros

  // Codes 0 to 11 belong to the arithmetic unit
  // and 12 to 15 to the shift and bit-count unit
  typedef enum logic [opWidth-1:0]
  {
    opAnd  = 4'd0,
    opOr   = 4'd1,
    opXor  = 4'd2,
    opNand = 4'd3,
    opNor  = 4'd4,
    opXnor = 4'd5,
    opAddU = 4'd6,   // Carry out
    opSubU = 4'd7,   // Borrow in carry
    opAddS = 4'd8,   // Signed overflow
    opSubS = 4'd9,
    opSlt  = 4'd10,
    opSltu = 4'd11,
    opSllv = 4'd12,
    opSrlv = 4'd13,
    opClo  = 4'd14,
    opClz  = 4'd15
  } aluOp_t;

endpackage

`default_nettype wire

/* aluResultMerge.sv */
`timescale 1ns/1ns
`default_nettype none

module aluResultMerge
(
  input  logic          clk,
  input  logic          rst,
  input  logic          arithValid,
  input  aluPkg::data_t arithResult,
  input  logic          arithCarry,
  input  logic          arithOverflow,
  input  logic          shiftValid,
  input  aluPkg::data_t shiftResult,
  output logic          resValid,
  output aluPkg::data_t result,
  output logic          carryFlag,
  output logic          overflowFlag,
  output logic          zeroFlag,
  output logic          negativeFlag
);

  logic          anyClaim;
  aluPkg::data_t selResult;
  logic          selCarry;
  logic          selOverflow;
  logic          selZero;
  logic          selNegative;

  // At most one unit claims per cycle
  assign anyClaim = arithValid || shiftValid;

  // Pick by strobe, no op decode needed here
  assign selResult = arithValid ? arithResult : shiftResult;

  // Shift unit never sets carry or overflow
  assign selCarry    = arithValid && arithCarry;
  assign selOverflow = arithValid && arithOverflow;

  // Flags shared by every operation
  assign selZero     = (selResult == '0);
  assign selNegative = selResult[aluPkg::signBit];

  always_ff @(posedge clk)
  begin
    if (rst)
      resValid <= 1'b0;
    else
      resValid <= anyClaim;
  end

  // Outputs hold their last values between strobes
  always_ff @(posedge clk)
  begin
    if (anyClaim)
    begin
      result       <= selResult;
      carryFlag    <= selCarry;
      overflowFlag <= selOverflow;
      zeroFlag     <= selZero;
      negativeFlag <= selNegative;
    end
  end

endmodule

`default_nettype wire

/* aluTbModel.svh */
`ifndef ALU_TB_MODEL_SVH
`define ALU_TB_MODEL_SVH

// Packed as {result, carry, overflow, zero, negative}
typedef logic [aluPkg::dataWidth+3:0] expect_t;

expect_t expQueue[$];    // Expected values in issue order
int      issueQueue[$];  // Cycle in which each op was presented

// Reference model built from the flag rules, using 64-bit arithmetic
function automatic expect_t modelAlu(input aluPkg::aluOp_t opCode,
                                     input aluPkg::data_t opA,
                                     input aluPkg::data_t opB);
  aluPkg::data_t   res;
  logic            carry;
  logic            ovf;
  logic            target;
  bit              done;
  int              n;
  longint          sa;
  longint          sb;
  longint          sWide;
  longint unsigned ua;
  longint unsigned ub;
  res   = '0;
  carry = 1'b0;
  ovf   = 1'b0;
  sa    = $signed(opA);  // Sign extended to 64 bits
  sb    = $signed(opB);
  ua    = opA;
  ub    = opB;
  case (opCode)
    aluPkg::opAnd:  res = opA & opB;
    aluPkg::opOr:   res = opA | opB;
    aluPkg::opXor:  res = opA ^ opB;
    aluPkg::opNand: res = ~(opA & opB);
    aluPkg::opNor:  res = ~(opA | opB);
    aluPkg::opXnor: res = ~(opA ^ opB);
    aluPkg::opAddU:
    begin
      res   = opA + opB;
      carry = (ua + ub) > 64'h0000_0000_FFFF_FFFF;
    end
    aluPkg::opSubU:
    begin
      res   = opA - opB;
      carry = (ua < ub);  // Borrow
    end
    aluPkg::opAddS, aluPkg::opSubS:
    begin
      sWide = (opCode == aluPkg::opAddS) ? sa + sb : sa - sb;
      res   = sWide[31:0];
      // Overflow when the true sum does not fit in 32 signed bits
      ovf   = (sWide != longint'($signed(res)));
    end
    aluPkg::opSlt:  res = (sa < sb) ? 32'd1 : 32'd0;
    aluPkg::opSltu: res = (ua < ub) ? 32'd1 : 32'd0;
    aluPkg::opSllv: res = opA << opB[4:0];
    aluPkg::opSrlv: res = opA >> opB[4:0];
    default:
    begin
      // Leading ones for opClo, leading zeros for opClz
      target = (opCode == aluPkg::opClo);
      n      = 0;
      done   = 0;
      for (int i = aluPkg::dataWidth - 1; i >= 0; i--)
      begin
        if (!done && (opA[i] == target))
          n++;
        else
          done = 1;
      end
      res = n;
    end
  endcase
  modelAlu = {res, carry, ovf, (res == '0), res[aluPkg::dataWidth-1]};
endfunction

task automatic pushExpected(input expect_t value, input int issueCycle);
  expQueue.push_back(value);
  issueQueue.push_back(issueCycle);
endtask

task automatic popExpected(output expect_t value, output int issueCycle);
  value      = expQueue.pop_front();
  issueCycle = issueQueue.pop_front();
endtask

`endif

/* aluTb.sv */
`timescale 1ns/1ns
`default_nettype none

module aluTb;

  localparam int clkPeriod   = 20;
  localparam int resetCycles = 4;
  localparam int driveDelay  = 2;
  localparam int numSlots    = 2000;  // Stimulus cycles of which about 3 in 4 carry an op
  localparam int marginCycles = 100;
  localparam int drainCycles = 10;
  localparam int watchdogTime = (numSlots + marginCycles) * clkPeriod;

  logic           clk;
  logic           rst;
  logic           opValid;
  aluPkg::aluOp_t op;
  aluPkg::data_t  a;
  aluPkg::data_t  b;
  logic           resValid;
  aluPkg::data_t  result;
  logic           carryFlag;
  logic           overflowFlag;
  logic           zeroFlag;
  logic           negativeFlag;

  integer seed = 32'he7f4;
  int     cycleCount = 0;
  int     errCount = 0;
  int     checkCount = 0;
  int     opCount = 0;

  `include "aluTbModel.svh"

  aluTop i_dut
  (
    .clk          (clk),
    .rst          (rst),
    .opValid      (opValid),
    .op           (op),
    .a            (a),
    .b            (b),
    .resValid     (resValid),
    .result       (result),
    .carryFlag    (carryFlag),
    .overflowFlag (overflowFlag),
    .zeroFlag     (zeroFlag),
    .negativeFlag (negativeFlag)
  );

  always #(clkPeriod / 2) clk = ~clk;

  always @(posedge clk)
    cycleCount <= cycleCount + 1;

  // Corner values one time in four and fully random otherwise
  function automatic aluPkg::data_t drawOperand();
    logic [31:0] pick;
    logic [31:0] value;
    pick  = $random(seed);
    value = $random(seed);
    if (pick[1:0] != 2'd0)
      drawOperand = value;
    else
    begin
      case (pick[4:2])
        3'd0:    drawOperand = 32'h0000_0000;
        3'd1:    drawOperand = 32'hFFFF_FFFF;
        3'd2:    drawOperand = 32'h8000_0000;  // Most negative
        3'd3:    drawOperand = 32'h7FFF_FFFF;  // Most positive
        default: drawOperand = 32'h1 << value[4:0];
      endcase
    end
  endfunction

  task automatic compareField(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    checkCount++;
    if (expected !== actual)
    begin
      errCount++;
      $display("ERR %0t %s expected %0h got %0h", $time, name, expected, actual);
    end
  endtask

  // One stimulus slot driven just after a rising edge
  task automatic driveSlot();
    logic [31:0] rnd;
    rnd = $random(seed);
    op  = aluPkg::aluOp_t'(rnd[7:4]);
    a   = drawOperand();
    b   = drawOperand();
    if (rnd[1:0] != 2'd0)
    begin
      opValid = 1'b1;
      pushExpected(modelAlu(op, a, b), cycleCount);
      opCount++;
    end
    else
      opValid = 1'b0;  // Operands left as noise
  endtask

  // Outputs are settled at the falling edge
  always @(negedge clk)
  begin
    expect_t expected;
    int      issue;
    if (resValid === 1'b1)
    begin
      if (expQueue.size() == 0)
      begin
        errCount++;
        $display("resValid high at %0t with no operation outstanding", $time);
      end
      else
      begin
        popExpected(expected, issue);
        compareField("result", expected[35:4], result);
        compareField("carryFlag", expected[3], carryFlag);
        compareField("overflowFlag", expected[2], overflowFlag);
        compareField("zeroFlag", expected[1], zeroFlag);
        compareField("negativeFlag", expected[0], negativeFlag);
        if (cycleCount != issue + 2)
        begin
          errCount++;
          $display("Latency wrong at %0t: op presented in cycle %0d came out in cycle %0d",
                   $time, issue, cycleCount);
        end
      end
    end
  end

  initial
  begin
    #(watchdogTime);
    $display("Watchdog expired at %0t before the test finished", $time);
    $display("STATUS: FAIL");
    $finish;
  end

  initial
  begin
    clk     = 1'b0;
    rst     = 1'b1;
    opValid = 1'b1;  // Ops offered during reset must never come out
    op      = aluPkg::opAnd;
    a       = '0;
    b       = '0;
    for (int r = 0; r < resetCycles; r++)
    begin
      @(posedge clk);
      #driveDelay;
      op = r[0] ? aluPkg::opAnd : aluPkg::opClz;  // Both units see a strobe
    end
    rst     = 1'b0;
    opValid = 1'b0;
    repeat (2) @(posedge clk);  // Quiet cycles right after reset
    for (int slot = 0; slot < numSlots; slot++)
    begin
      @(posedge clk);
      #driveDelay;
      driveSlot();
    end
    @(posedge clk);
    #driveDelay;
    opValid = 1'b0;
    for (int w = 0; (w < drainCycles) && (expQueue.size() != 0); w++)
      @(posedge clk);
    repeat (4) @(posedge clk);  // Catch any stray strobe
    if (expQueue.size() != 0)
    begin
      errCount++;
      $display("%0d operations never produced a result", expQueue.size());
    end
    $display("Done: %0d operations, %0d checks, %0d errors", opCount, checkCount, errCount);
    if (errCount == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* aluTop.f */
+incdir+.
aluPkg.sv
aluArith.sv
aluBitCount.sv
aluResultMerge.sv
aluTop.sv
aluTb.sv

/* aluTop.sv */
`timescale 1ns/1ns
`default_nettype none

module aluTop
(
  input  logic           clk,
  input  logic           rst,
  input  logic           opValid,
  input  aluPkg::aluOp_t op,
  input  aluPkg::data_t  a,
  input  aluPkg::data_t  b,
  output logic           resValid,
  output aluPkg::data_t  result,
  output logic           carryFlag,
  output logic           overflowFlag,
  output logic           zeroFlag,
  output logic           negativeFlag
);

  // Stage 1 to stage 2
  logic          arithValid;
  aluPkg::data_t arithResult;
  logic          arithCarry;
  logic          arithOverflow;
  logic          shiftValid;
  aluPkg::data_t shiftResult;

  // Both units see every op and claim their own
  aluArith i_arith
  (
    .clk           (clk),
    .rst           (rst),
    .opValid       (opValid),
    .op            (op),
    .a             (a),
    .b             (b),
    .arithValid    (arithValid),
    .arithResult   (arithResult),
    .arithCarry    (arithCarry),
    .arithOverflow (arithOverflow)
  );

  aluBitCount i_bitCount
  (
    .clk         (clk),
    .rst         (rst),
    .opValid     (opValid),
    .op          (op),
    .a           (a),
    .b           (b),
    .shiftValid  (shiftValid),
    .shiftResult (shiftResult)
  );

  aluResultMerge i_merge
  (
    .clk           (clk),
    .rst           (rst),
    .arithValid    (arithValid),
    .arithResult   (arithResult),
    .arithCarry    (arithCarry),
    .arithOverflow (arithOverflow),
    .shiftValid    (shiftValid),
    .shiftResult   (shiftResult),
    .resValid      (resValid),
    .result        (result),
    .carryFlag     (carryFlag),
    .overflowFlag  (overflowFlag),
    .zeroFlag      (zeroFlag),
    .negativeFlag  (negativeFlag)
  );

endmodule

`default_nettype wire
